// File: hw/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  parameter int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes kept by the core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011
  } opcode_t;

  parameter logic [2:0] f3_add_sub = 3'b000;
  parameter logic [2:0] f3_sll     = 3'b001;
  parameter logic [2:0] f3_slt     = 3'b010;
  parameter logic [2:0] f3_xor     = 3'b100;
  parameter logic [2:0] f3_srl_sra = 3'b101;
  parameter logic [2:0] f3_or      = 3'b110;
  parameter logic [2:0] f3_and     = 3'b111;
  parameter logic [2:0] f3_beq     = 3'b000;
  parameter logic [2:0] f3_bne     = 3'b001;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_link
  } wb_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one fetched word, seen through every encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;
    logic    reg_write;
    logic    mem_write;
    wb_sel_t wb_sel;
    logic    is_branch;
    logic    branch_on_equal;
    logic    is_jal;
    logic    is_jalr;
    word_t   imm;
  } ctrl_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     instr;
    logic      rd_write;
    reg_addr_t rd;
    word_t     rd_data;
  } retire_t;

  typedef struct packed {
    logic  valid;
    word_t addr;
    word_t data;
  } store_t;

endpackage

`default_nettype wire

// File: hw/instr_mem.sv
`timescale 1ns/1ns
`default_nettype none

module instr_mem #(
  parameter int imem_depth = 64
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(imem_depth)-1:0] waddr,
  input  rv_core_pkg::word_t            wdata,
  input  rv_core_pkg::word_t            pc,
  output rv_core_pkg::instr_t           instr
);
  import rv_core_pkg::*;

  localparam int aw = $clog2(imem_depth);

  word_t mem [imem_depth];

  // program load, only used while the core is halted
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // byte address to word index
  assign instr = mem[pc[aw+1:2]];

endmodule

`default_nettype wire

// File: hw/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder (
  input  rv_core_pkg::instr_t instr,
  output rv_core_pkg::ctrl_t  ctrl
);
  import rv_core_pkg::*;

  logic [2:0] funct3;
  logic       funct7_5;
  logic       is_reg_op;
  logic       alu_ok;
  alu_op_t    alu_sel;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign funct3    = instr.r.funct3;
  assign funct7_5  = instr.r.funct7[5];
  assign is_reg_op = (instr.r.opcode == opc_op);

  assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
  assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign imm_b = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                  instr.b.imm_4_1, 1'b0};
  assign imm_u = {instr.u.imm_31_12, 12'b0};
  assign imm_j = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                  instr.j.imm_10_1, 1'b0};

  // funct decode shared by op and op_imm
  always_comb begin
    alu_ok  = 1'b1;
    alu_sel = alu_add;
    case (funct3)
      f3_add_sub: alu_sel = (is_reg_op && funct7_5) ? alu_sub : alu_add;
      f3_sll:     alu_sel = alu_sll;
      f3_xor:     alu_sel = alu_xor;
      f3_srl_sra: alu_sel = funct7_5 ? alu_sra : alu_srl;
      f3_or:      alu_sel = alu_or;
      f3_and:     alu_sel = alu_and;
      f3_slt: begin
        // slti is not supported
        alu_sel = alu_slt;
        alu_ok  = is_reg_op;
      end
      default:    alu_ok = 1'b0;
    endcase
  end

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.wb_sel = wb_alu;
    case (instr.r.opcode)
      opc_op: begin
        ctrl.alu_op    = alu_sel;
        ctrl.reg_write = alu_ok;
      end
      opc_op_imm: begin
        ctrl.alu_op    = alu_sel;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = alu_ok;
        ctrl.imm       = imm_i;
      end
      opc_lui: begin
        ctrl.alu_op    = alu_pass_b;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.imm       = imm_u;
      end
      opc_load: begin
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_mem;
        ctrl.imm       = imm_i;
      end
      opc_store: begin
        ctrl.use_imm   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.imm       = imm_s;
      end
      opc_jal: begin
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_link;
        ctrl.imm       = imm_j;
      end
      opc_jalr: begin
        ctrl.is_jalr   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_link;
        ctrl.imm       = imm_i;
      end
      opc_branch: begin
        // only beq and bne, other conditions fall through as no-ops
        ctrl.is_branch       = (funct3 == f3_beq) || (funct3 == f3_bne);
        ctrl.branch_on_equal = (funct3 == f3_beq);
        ctrl.imm             = imm_b;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we,
  input  rv_core_pkg::reg_addr_t rs1,
  input  rv_core_pkg::reg_addr_t rs2,
  input  rv_core_pkg::reg_addr_t rd,
  input  rv_core_pkg::word_t     wdata,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data
);
  import rv_core_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // x0 never written, so it stays zero
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  rv_core_pkg::word_t   a,
  input  rv_core_pkg::word_t   b,
  input  rv_core_pkg::alu_op_t op,
  output rv_core_pkg::word_t   result,
  output logic                 equal
);
  import rv_core_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // branch compare on the register operands
  assign equal = (a == b);

endmodule

`default_nettype wire

// File: hw/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

module data_mem #(
  parameter int dmem_depth = 64
) (
  input  logic               clk,
  input  logic               we,
  input  rv_core_pkg::word_t addr,
  input  rv_core_pkg::word_t wdata,
  output rv_core_pkg::word_t rdata
);
  import rv_core_pkg::*;

  localparam int aw = $clog2(dmem_depth);

  word_t mem [dmem_depth];
  logic [aw-1:0] index;

  // word accesses only, low address bits ignored
  assign index = addr[aw+1:2];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end
  end

  assign rdata = mem[index];

endmodule

`default_nettype wire

// File: hw/next_pc.sv
`timescale 1ns/1ns
`default_nettype none

module next_pc (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::word_t rs1_data,
  input  logic               equal,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t pc_plus4
);
  import rv_core_pkg::*;

  word_t target;
  word_t jalr_sum;
  word_t pc_next;
  logic  take_branch;

  assign pc_plus4    = pc + 32'd4;
  // jal and branches share one adder
  assign target      = pc + ctrl.imm;
  assign jalr_sum    = rs1_data + ctrl.imm;
  assign take_branch = ctrl.is_branch && (equal == ctrl.branch_on_equal);

  always_comb begin
    if (ctrl.is_jalr) begin
      pc_next = {jalr_sum[xlen-1:1], 1'b0};
    end else if (ctrl.is_jal || take_branch) begin
      pc_next = target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // pc holds while halted
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter int imem_depth = 64,
  parameter int dmem_depth = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          run,
  input  logic                          imem_we,
  input  logic [$clog2(imem_depth)-1:0] imem_addr,
  input  rv_core_pkg::word_t            imem_data,
  output rv_core_pkg::retire_t          retire,
  output rv_core_pkg::store_t           store
);
  import rv_core_pkg::*;

  word_t  pc;
  word_t  pc_plus4;
  instr_t instr;
  ctrl_t  ctrl;
  word_t  rs1_data;
  word_t  rs2_data;
  word_t  alu_b;
  word_t  alu_result;
  logic   equal;
  word_t  mem_rdata;
  word_t  wb_data;
  logic   active;
  logic   reg_we;
  logic   mem_we;

  // nothing commits unless the core is running and out of reset
  assign active = run && !rst;
  assign reg_we = active && ctrl.reg_write;
  assign mem_we = active && ctrl.mem_write;

  next_pc u_next_pc (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .equal    (equal),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  instr_mem #(
    .imem_depth (imem_depth)
  ) u_instr_mem (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_data),
    .pc    (pc),
    .instr (instr)
  );

  decoder u_decoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we),
    .rs1      (instr.r.rs1),
    .rs2      (instr.r.rs2),
    .rd       (instr.r.rd),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  alu u_alu (
    .a      (rs1_data),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .equal  (equal)
  );

  data_mem #(
    .dmem_depth (dmem_depth)
  ) u_data_mem (
    .clk   (clk),
    .we    (mem_we),
    .addr  (alu_result),
    .wdata (rs2_data),
    .rdata (mem_rdata)
  );

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wb_data = mem_rdata;
      wb_link: wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // records of the instruction executing this cycle
  assign retire.valid    = active;
  assign retire.pc       = pc;
  assign retire.instr    = instr;
  assign retire.rd_write = reg_we;
  assign retire.rd       = instr.r.rd;
  assign retire.rd_data  = wb_data;

  assign store.valid = mem_we;
  assign store.addr  = alu_result;
  assign store.data  = rs2_data;

endmodule

`default_nettype wire

// File: verif/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;
  import rv_core_pkg::*;

  localparam int imem_words   = 64;
  localparam int dmem_words   = 64;
  localparam int iaw          = $clog2(imem_words);
  localparam int daw          = $clog2(dmem_words);
  localparam int reset_cycles = 16;
  localparam int n_tests      = 6;
  localparam int max_run      = 48;
  localparam int cycle_limit  = n_tests * (reset_cycles + imem_words + 2 + max_run) + 200;

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;

  localparam logic [2:0] fn_add = 3'b000;
  localparam logic [2:0] fn_sll = 3'b001;
  localparam logic [2:0] fn_slt = 3'b010;
  localparam logic [2:0] fn_xor = 3'b100;
  localparam logic [2:0] fn_sr  = 3'b101;
  localparam logic [2:0] fn_or  = 3'b110;
  localparam logic [2:0] fn_and = 3'b111;

  logic                clk;
  logic                rst;
  logic                run;
  logic                imem_we;
  logic [iaw-1:0]      imem_addr;
  word_t               imem_data;
  retire_t             retire;
  store_t              store;

  // reference model state
  word_t mregs [32];
  word_t mpc;
  word_t mimem [imem_words];
  word_t mdmem [dmem_words];
  word_t prog [$];
  word_t rng = 32'd61060;

  int checks       = 0;
  int mismatches   = 0;
  int other_errors = 0;
  int cycle_count  = 0;

  rv_core #(
    .imem_depth (imem_words),
    .dmem_depth (dmem_words)
  ) u_rv_core (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .retire    (retire),
    .store     (store)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic word_t xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rand_imm12();
    word_t r;
    r = xorshift();
    return int'(r[11:0]);
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
  endfunction

  function automatic word_t enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  // slli, srli and srai carry funct7 above the shift amount
  function automatic word_t enc_shift(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int sh);
    return {f7, sh[4:0], rs1[4:0], f3, rd[4:0], op_imm};
  endfunction

  function automatic word_t enc_lui(int rd, logic [19:0] upper);
    return {upper, rd[4:0], op_lui};
  endfunction

  function automatic word_t enc_sw(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_b(logic [2:0] f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t enc_jal(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
  endfunction

  // lui plus addi with the upper part rounded for the signed low half
  task automatic load_const(int rd, word_t v);
    word_t hi;
    hi = (v + 32'h800) >> 12;
    prog.push_back(enc_lui(rd, hi[19:0]));
    prog.push_back(enc_i(op_imm, fn_add, rd, rd, int'(v[11:0])));
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      fn_add:  return alt ? a - b : a + b;
      fn_sll:  return a << b[4:0];
      fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      fn_xor:  return a ^ b;
      fn_sr:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      fn_or:   return a | b;
      fn_and:  return a & b;
      default: return '0;
    endcase
  endfunction

  // one executed instruction of the model
  function automatic void model_step(output retire_t r, output store_t s);
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    word_t      next;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    logic [2:0] f3;
    logic       wr;
    ins   = mimem[mpc[iaw+1:2]];
    f3    = ins[14:12];
    a     = mregs[ins[19:15]];
    b     = mregs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    wr    = 1'b0;
    res   = '0;
    next  = mpc + 32'd4;
    s     = '0;
    case (ins[6:0])
      op_reg: begin
        wr  = (f3 != 3'b011);
        res = alu_ref(f3, ins[30], a, b);
      end
      op_imm: begin
        // no slti or sltiu
        wr  = (f3 != fn_slt) && (f3 != 3'b011);
        res = alu_ref(f3, (f3 == fn_sr) && ins[30], a, imm_i);
      end
      op_lui: begin
        wr  = 1'b1;
        res = {ins[31:12], 12'b0};
      end
      op_load: begin
        wr   = 1'b1;
        addr = a + imm_i;
        res  = mdmem[addr[daw+1:2]];
      end
      op_store: begin
        addr   = a + imm_s;
        s.valid = 1'b1;
        s.addr  = addr;
        s.data  = b;
        mdmem[addr[daw+1:2]] = b;
      end
      op_jal: begin
        wr   = 1'b1;
        res  = mpc + 32'd4;
        next = mpc + imm_j;
      end
      op_jalr: begin
        wr   = 1'b1;
        res  = mpc + 32'd4;
        next = (a + imm_i) & ~32'd1;
      end
      op_branch: begin
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
          next = mpc + imm_b;
        end
      end
      default: ;
    endcase
    r          = '0;
    r.valid    = 1'b1;
    r.pc       = mpc;
    r.instr    = ins;
    r.rd_write = wr;
    r.rd       = ins[11:7];
    r.rd_data  = wr ? res : '0;
    if (wr && ins[11:7] != 5'd0) begin
      mregs[ins[11:7]] = res;
    end
    mpc = next;
  endfunction

  // halted core still shows its pc and fetched word
  function automatic void model_idle(output retire_t r, output store_t s);
    r       = '0;
    r.pc    = mpc;
    r.instr = mimem[mpc[iaw+1:2]];
    r.rd    = r.instr[11:7];
    s       = '0;
  endfunction

  function automatic string retire_text(retire_t r);
    return $sformatf("v=%b pc=%h ins=%h w=%b rd=%0d d=%h",
                     r.valid, r.pc, r.instr, r.rd_write, r.rd, r.rd_data);
  endfunction

  task automatic check_retire(string name, retire_t exp, retire_t act);
    checks++;
    if (!exp.rd_write) begin
      exp.rd_data = '0;
      act.rd_data = '0;
    end
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s retire: expected %s, actual %s",
               name, retire_text(exp), retire_text(act));
    end
  endtask

  task automatic check_store(string name, store_t exp, store_t act);
    checks++;
    if (!exp.valid) begin
      exp.addr = '0;
      exp.data = '0;
      act.addr = '0;
      act.data = '0;
    end
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s store: expected v=%b addr=%h data=%h, actual v=%b addr=%h data=%h",
               name, exp.valid, exp.addr, exp.data, act.valid, act.addr, act.data);
    end
  endtask

  // reset and then fill the whole instruction memory with run low
  task automatic load_program();
    rst = 1'b1;
    run = 1'b0;
    repeat (reset_cycles) begin
      @(posedge clk);
      #2;
    end
    rst = 1'b0;
    if (prog.size() > imem_words) begin
      other_errors++;
      $display("error: program of %0d words does not fit in instruction memory", prog.size());
    end
    for (int i = 0; i < imem_words; i++) begin
      if (i < prog.size()) begin
        mimem[i] = prog[i];
      end else begin
        // addi x0, x0, index as address-dependent filler
        mimem[i] = enc_i(op_imm, fn_add, 0, 0, i);
      end
      imem_we   = 1'b1;
      imem_addr = i[iaw-1:0];
      imem_data = mimem[i];
      @(posedge clk);
      #2;
    end
    imem_we = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    mpc = '0;
  endtask

  task automatic run_cycles(string name, int n, logic on);
    retire_t exp_r;
    store_t  exp_s;
    run = on;
    repeat (n) begin
      if (on) begin
        model_step(exp_r, exp_s);
      end else begin
        model_idle(exp_r, exp_s);
      end
      // sample just before the next rising edge
      #35;
      check_retire(name, exp_r, retire);
      check_store(name, exp_s, store);
      @(posedge clk);
      #2;
    end
    run = 1'b0;
  endtask

  task automatic test_arith();
    prog.delete();
    load_const(1, xorshift());
    load_const(2, xorshift());
    prog.push_back(enc_r(7'h00, fn_add, 4, 1, 2));
    prog.push_back(enc_r(7'h20, fn_add, 5, 1, 2));
    prog.push_back(enc_r(7'h00, fn_and, 6, 1, 2));
    prog.push_back(enc_r(7'h00, fn_or, 7, 1, 2));
    prog.push_back(enc_r(7'h00, fn_xor, 8, 1, 2));
    prog.push_back(enc_i(op_imm, fn_and, 9, 1, rand_imm12()));
    prog.push_back(enc_i(op_imm, fn_or, 10, 2, rand_imm12()));
    prog.push_back(enc_i(op_imm, fn_xor, 11, 1, rand_imm12()));
    prog.push_back(enc_i(op_imm, fn_add, 12, 2, rand_imm12()));
    load_program();
    run_cycles("arith", prog.size(), 1'b1);
  endtask

  task automatic test_shift_compare();
    prog.delete();
    load_const(1, xorshift() | 32'h8000_0000);
    // upper bits of the shift register must be ignored
    load_const(2, xorshift());
    load_const(10, xorshift() | 32'h8000_0000);
    load_const(11, xorshift() & 32'h7fff_ffff);
    prog.push_back(enc_r(7'h00, fn_sll, 3, 1, 2));
    prog.push_back(enc_r(7'h00, fn_sr, 4, 1, 2));
    prog.push_back(enc_r(7'h20, fn_sr, 5, 1, 2));
    prog.push_back(enc_shift(7'h00, fn_sll, 6, 1, rand_imm12()));
    prog.push_back(enc_shift(7'h00, fn_sr, 7, 1, rand_imm12()));
    prog.push_back(enc_shift(7'h20, fn_sr, 8, 1, rand_imm12()));
    prog.push_back(enc_r(7'h00, fn_slt, 12, 10, 11));
    prog.push_back(enc_r(7'h00, fn_slt, 13, 11, 10));
    prog.push_back(enc_r(7'h00, fn_slt, 14, 10, 10));
    prog.push_back(enc_r(7'h00, fn_slt, 15, 1, 10));
    load_program();
    run_cycles("shift_compare", prog.size(), 1'b1);
  endtask

  task automatic test_memory();
    prog.delete();
    load_const(1, 32'h40);
    load_const(2, xorshift());
    load_const(3, xorshift());
    load_const(6, 32'h80);
    prog.push_back(enc_sw(2, 1, 0));
    prog.push_back(enc_sw(3, 1, 8));
    prog.push_back(enc_sw(2, 6, -4));
    prog.push_back(enc_i(op_load, 3'b010, 4, 1, 0));
    prog.push_back(enc_i(op_load, 3'b010, 5, 1, 8));
    prog.push_back(enc_i(op_load, 3'b010, 7, 6, -4));
    prog.push_back(enc_sw(3, 1, 0));
    prog.push_back(enc_i(op_load, 3'b010, 8, 1, 0));
    load_program();
    run_cycles("memory", prog.size(), 1'b1);
  endtask

  task automatic test_branch();
    prog.delete();
    prog.push_back(enc_i(op_imm, fn_add, 1, 0, 5));
    prog.push_back(enc_i(op_imm, fn_add, 2, 0, 5));
    prog.push_back(enc_i(op_imm, fn_add, 3, 0, 7));
    prog.push_back(enc_b(3'b000, 1, 2, 8));
    prog.push_back(enc_i(op_imm, fn_add, 10, 0, 1));
    prog.push_back(enc_b(3'b000, 1, 3, 8));
    prog.push_back(enc_b(3'b001, 1, 3, 8));
    prog.push_back(enc_i(op_imm, fn_add, 11, 0, 1));
    prog.push_back(enc_b(3'b001, 1, 2, 8));
    prog.push_back(enc_i(op_imm, fn_add, 12, 0, 3));
    prog.push_back(enc_b(3'b000, 0, 0, 8));
    prog.push_back(enc_i(op_imm, fn_add, 13, 0, 1));
    prog.push_back(enc_i(op_imm, fn_add, 14, 0, 9));
    // backward loop until x15 reaches 7
    prog.push_back(enc_i(op_imm, fn_add, 15, 15, 1));
    prog.push_back(enc_b(3'b001, 15, 3, -4));
    load_program();
    run_cycles("branch", 28, 1'b1);
  endtask

  task automatic test_jump();
    prog.delete();
    prog.push_back(enc_jal(1, 12));
    prog.push_back(enc_i(op_imm, fn_add, 6, 0, 1));
    prog.push_back(enc_jal(0, 16));
    prog.push_back(enc_i(op_imm, fn_add, 2, 0, 33));
    // odd target whose bit 0 is dropped
    prog.push_back(enc_i(op_jalr, 3'b000, 3, 2, -28));
    prog.push_back(enc_i(op_imm, fn_add, 12, 0, 1));
    prog.push_back(enc_i(op_jalr, 3'b000, 7, 1, 25));
    prog.push_back(enc_jal(8, 12));
    prog.push_back(enc_i(op_imm, fn_add, 13, 0, 1));
    prog.push_back(enc_jal(0, 8));
    prog.push_back(enc_jal(9, -4));
    prog.push_back(enc_i(op_imm, fn_add, 14, 0, 5));
    load_program();
    run_cycles("jump", 12, 1'b1);
  endtask

  task automatic test_control();
    prog.delete();
    for (int r = 1; r < 32; r++) begin
      prog.push_back(enc_r(7'h00, fn_add, r, r, 0));
    end
    prog.push_back(enc_i(op_imm, fn_add, 0, 0, 123));
    prog.push_back(enc_lui(0, 20'h12345));
    prog.push_back(enc_r(7'h00, fn_add, 1, 0, 0));
    prog.push_back(enc_i(op_imm, fn_add, 2, 0, -1));
    prog.push_back(enc_r(7'h00, fn_xor, 3, 2, 0));
    load_program();
    run_cycles("control", 3, 1'b0);
    run_cycles("control", 20, 1'b1);
    run_cycles("control", 4, 1'b0);
    run_cycles("control", prog.size() - 20, 1'b1);
  endtask

  initial begin : watchdog
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("error: timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    run       = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    @(posedge clk);
    #2;
    test_arith();
    test_shift_compare();
    test_memory();
    test_branch();
    test_jump();
    // runs last so registers hold earlier values before its reset
    test_control();
    $display("summary: %0d checks, %0d mismatches, %0d other errors",
             checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/rv_core_pkg.sv
hw/instr_mem.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/data_mem.sv
hw/next_pc.sv
hw/rv_core.sv
verif/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
